/* rtl/rcn_pkg.sv */
// ring packet format shared by every ring stage, the slot interface and the testbench
package rcn_pkg;

    localparam int SEQ_W  = 4;
    localparam int MASK_W = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [SEQ_W-1:0]  rcn_seq_t;
    typedef logic [MASK_W-1:0] rcn_mask_t;
    typedef logic [ADDR_W-1:0] rcn_addr_t;
    typedef logic [DATA_W-1:0] rcn_data_t;

    // one ring slot, valid low means the slot is empty
    typedef struct packed {
        logic      valid;
        logic      rsp;   // set by the node that claimed the request
        logic      wr;
        logic      err;   // no node claimed the address
        rcn_seq_t  seq;
        rcn_mask_t mask;  // byte enable, bit 0 is data[7:0]
        rcn_addr_t addr;
        rcn_data_t data;
    } rcn_pkt_t;

    // byte-masked update of a stored word
    function automatic rcn_data_t merge_bytes(rcn_data_t old_word, rcn_data_t new_word,
                                              rcn_mask_t mask);
        rcn_data_t res;
        res = old_word;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b])
                res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

endpackage

/* rtl/ring_cfg_pkg.sv */
// address map, sizes and flow-control constants of the ring subsystem
package ring_cfg_pkg;

    // progress, fail and pass at offsets 0, 4 and 8
    localparam logic [31:0] TESTREGS_BASE  = 32'hFFFFFFF0;
    localparam int          TESTREGS_COUNT = 3;

    localparam logic [31:0] RAM_BASE  = 32'h00000000;
    localparam int          RAM_WORDS = 256;

    // master queue depth, also the credits the source owns after reset
    localparam int REQ_CREDITS = 4;

    // length of the wiring delay stage
    localparam int RING_DELAY = 16;

endpackage

/* rtl/rcn_if.sv */
// one ring slot between two stages, the upstream stage drives and the downstream reads
`timescale 1ns/1ps

interface rcn_if;

    rcn_pkg::rcn_pkt_t pkt;

    modport snd (
        output pkt
    );

    modport rcv (
        input pkt
    );

endinterface

/* rtl/rcn_master.sv */
// ring master that queues credited requests, injects them into the ring and extracts responses
`timescale 1ns/1ps

module rcn_master (
    input  logic               clk,
    input  logic               reset,

    input  logic               req_valid,
    input  logic               req_wr,
    input  rcn_pkg::rcn_addr_t req_addr,
    input  rcn_pkg::rcn_mask_t req_mask,
    input  rcn_pkg::rcn_data_t req_data,
    output logic               req_credit,

    output logic               rsp_valid,
    output rcn_pkg::rcn_seq_t  rsp_seq,
    output rcn_pkg::rcn_data_t rsp_data,
    output logic               rsp_err,

    rcn_if.rcv                 ring_in,
    rcn_if.snd                 ring_out
);

    localparam int DEPTH = ring_cfg_pkg::REQ_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rcn_pkg::rcn_pkt_t fifo [DEPTH];
    rcn_pkg::rcn_pkt_t out_pkt;

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    rcn_pkg::rcn_seq_t seq_cnt;

    logic take;
    logic inject;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // single master, so every packet that comes back around is ours
    assign take   = ring_in.pkt.valid;
    assign inject = (count != '0); // every incoming slot is taken or empty, so a slot is always free

    always_ff @(posedge clk) begin
        if (req_valid)
            fifo[wr_ptr] <= '{valid: 1'b1, rsp: 1'b0, wr: req_wr, err: 1'b0, seq: seq_cnt,
                              mask: req_mask, addr: req_addr, data: req_data};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            seq_cnt    <= '0;
            req_credit <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr  <= next_ptr(wr_ptr);
                seq_cnt <= seq_cnt + 1'b1; // tags follow acceptance order
            end
            if (inject)
                rd_ptr <= next_ptr(rd_ptr);
            case ({req_valid, inject})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            req_credit <= inject; // one credit back per injected request
            rsp_valid  <= take;
        end
    end

    // unclaimed requests come back as requests and are reported as errors
    always_ff @(posedge clk) begin
        rsp_seq  <= ring_in.pkt.seq;
        rsp_data <= ring_in.pkt.rsp ? ring_in.pkt.data : '0;
        rsp_err  <= ring_in.pkt.err || !ring_in.pkt.rsp;
    end

    always_ff @(posedge clk) begin
        out_pkt <= fifo[rd_ptr];
        if (reset)
            out_pkt.valid <= 1'b0;
        else
            out_pkt.valid <= inject;
    end

    assign ring_out.pkt = out_pkt;

endmodule

/* rtl/rcn_testregs.sv */
// ring node with the progress, fail and pass test registers, also driven out as plain outputs
`timescale 1ns/1ps

module rcn_testregs (
    input  logic        clk,
    input  logic        reset,

    rcn_if.rcv          ring_in,
    rcn_if.snd          ring_out,

    output logic [31:0] test_progress,
    output logic [31:0] test_fail,
    output logic [31:0] test_pass
);

    localparam logic [31:0] BASE  = ring_cfg_pkg::TESTREGS_BASE;
    localparam int          NREGS = ring_cfg_pkg::TESTREGS_COUNT;

    rcn_pkg::rcn_data_t tregs [NREGS];
    rcn_pkg::rcn_pkt_t  out_pkt;
    rcn_pkg::rcn_data_t cur_val;
    rcn_pkg::rcn_data_t merged;
    logic [1:0]         reg_idx;
    logic               hit;

    assign reg_idx = ring_in.pkt.addr[3:2];
    assign hit     = ring_in.pkt.valid && !ring_in.pkt.rsp &&
                     (ring_in.pkt.addr[31:4] == BASE[31:4]) &&
                     (int'(reg_idx) < NREGS); // word at offset 12 is not decoded

    assign cur_val = hit ? tregs[reg_idx] : '0;
    assign merged  = rcn_pkg::merge_bytes(cur_val, ring_in.pkt.data, ring_in.pkt.mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++)
                tregs[i] <= '0;
        end else if (hit && ring_in.pkt.wr) begin
            tregs[reg_idx] <= merged;
        end
    end

    // claimed requests turn into responses, same seq
    always_ff @(posedge clk) begin
        out_pkt <= ring_in.pkt;
        if (hit) begin
            out_pkt.rsp  <= 1'b1;
            out_pkt.data <= ring_in.pkt.wr ? merged : cur_val;
        end
        if (reset)
            out_pkt.valid <= 1'b0;
    end

    assign ring_out.pkt  = out_pkt;
    assign test_progress = tregs[0];
    assign test_fail     = tregs[1];
    assign test_pass     = tregs[2];

endmodule

/* rtl/rcn_ram.sv */
// ring node with a word RAM, byte-masked writes answer with the merged word
`timescale 1ns/1ps

module rcn_ram (
    input  logic clk,
    input  logic reset,

    rcn_if.rcv   ring_in,
    rcn_if.snd   ring_out
);

    localparam int          WORDS     = ring_cfg_pkg::RAM_WORDS;
    localparam int          IDX_W     = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [31:0] WIN_BYTES = 32'(WORDS * 4);

    rcn_pkg::rcn_data_t mem [WORDS];
    rcn_pkg::rcn_pkt_t  out_pkt;
    rcn_pkg::rcn_addr_t offs;
    rcn_pkg::rcn_data_t rd_word;
    rcn_pkg::rcn_data_t merged;
    logic [IDX_W-1:0]   word_idx;
    logic               hit;

    assign offs     = ring_in.pkt.addr - ring_cfg_pkg::RAM_BASE;
    assign word_idx = offs[IDX_W+1:2]; // byte lane bits ignored
    assign hit      = ring_in.pkt.valid && !ring_in.pkt.rsp && (offs < WIN_BYTES);

    assign rd_word = mem[word_idx];
    assign merged  = rcn_pkg::merge_bytes(rd_word, ring_in.pkt.data, ring_in.pkt.mask);

    always_ff @(posedge clk) begin
        if (hit && ring_in.pkt.wr)
            mem[word_idx] <= merged;
    end

    always_ff @(posedge clk) begin
        out_pkt <= ring_in.pkt;
        if (hit) begin
            out_pkt.rsp  <= 1'b1;
            out_pkt.data <= ring_in.pkt.wr ? merged : rd_word;
        end
        if (reset)
            out_pkt.valid <= 1'b0;
    end

    assign ring_out.pkt = out_pkt;

endmodule

/* rtl/rcn_delay.sv */
// ring stage that stands for wiring length and holds every slot back DELAY_CYCLES cycles
`timescale 1ns/1ps

module rcn_delay #(
    parameter int DELAY_CYCLES = 1
) (
    input  logic clk,
    input  logic reset,

    rcn_if.rcv   ring_in,
    rcn_if.snd   ring_out
);

    rcn_pkg::rcn_pkt_t chain [DELAY_CYCLES];

    always_ff @(posedge clk) begin
        chain[0] <= ring_in.pkt;
        for (int i = 1; i < DELAY_CYCLES; i++)
            chain[i] <= chain[i-1];
        // reset empties every slot in the chain
        if (reset) begin
            for (int i = 0; i < DELAY_CYCLES; i++)
                chain[i].valid <= 1'b0;
        end
    end

    assign ring_out.pkt = chain[DELAY_CYCLES-1];

endmodule

/* rtl/rcn_ring_top.sv */
// ring subsystem top, master plus test registers, RAM and delay closed into one ring
`timescale 1ns/1ps

module rcn_ring_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               req_valid,
    input  logic               req_wr,
    input  logic [31:0]        req_addr,
    input  logic [3:0]         req_mask,
    input  rcn_pkg::rcn_data_t req_data,
    output logic               req_credit,

    output logic               rsp_valid,
    output rcn_pkg::rcn_seq_t  rsp_seq,
    output rcn_pkg::rcn_data_t rsp_data,
    output logic               rsp_err,

    output logic [31:0]        test_progress,
    output logic [31:0]        test_fail,
    output logic [31:0]        test_pass
);

    rcn_if rcn_0 (); // delay -> master
    rcn_if rcn_1 (); // master -> test registers
    rcn_if rcn_2 (); // test registers -> ram
    rcn_if rcn_3 (); // ram -> delay

    rcn_master i_master (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_wr     (req_wr),
        .req_addr   (req_addr),
        .req_mask   (req_mask),
        .req_data   (req_data),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_seq    (rsp_seq),
        .rsp_data   (rsp_data),
        .rsp_err    (rsp_err),
        .ring_in    (rcn_0.rcv),
        .ring_out   (rcn_1.snd)
    );

    rcn_testregs i_testregs (
        .clk           (clk),
        .reset         (reset),
        .ring_in       (rcn_1.rcv),
        .ring_out      (rcn_2.snd),
        .test_progress (test_progress),
        .test_fail     (test_fail),
        .test_pass     (test_pass)
    );

    rcn_ram i_ram (
        .clk      (clk),
        .reset    (reset),
        .ring_in  (rcn_2.rcv),
        .ring_out (rcn_3.snd)
    );

    rcn_delay #(
        .DELAY_CYCLES (ring_cfg_pkg::RING_DELAY)
    ) i_delay (
        .clk      (clk),
        .reset    (reset),
        .ring_in  (rcn_3.rcv),
        .ring_out (rcn_0.snd)
    );

endmodule

/* tb/rcn_ring_tb.sv */
// testbench that replays the ring test data file through the ring subsystem and checks responses
`timescale 1ns/1ps

module rcn_ring_tb;

    localparam int RING_LAT = 19; // injection to rsp_valid
    localparam int MAX_GAP  = 3;

    logic               clk;
    logic               reset;
    logic               req_valid;
    logic               req_wr;
    logic [31:0]        req_addr;
    logic [3:0]         req_mask;
    rcn_pkg::rcn_data_t req_data;
    logic               req_credit;
    logic               rsp_valid;
    rcn_pkg::rcn_seq_t  rsp_seq;
    rcn_pkg::rcn_data_t rsp_data;
    logic               rsp_err;
    logic [31:0]        test_progress;
    logic [31:0]        test_fail;
    logic [31:0]        test_pass;

    int                 op_kind [$];
    logic [31:0]        op_addr [$];
    logic [3:0]         op_mask [$];
    rcn_pkg::rcn_data_t op_wdata [$];
    rcn_pkg::rcn_data_t op_exp [$];
    logic               op_err [$];

    // expected responses in issue order
    rcn_pkg::rcn_seq_t  exp_seq_q [$];
    rcn_pkg::rcn_data_t exp_data_q [$];
    logic               exp_err_q [$];

    int                 n_ops = 0;
    int                 credits;
    int                 gap;
    rcn_pkg::rcn_seq_t  next_seq;

    rcn_ring_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_seq(string name, rcn_pkg::rcn_seq_t got, rcn_pkg::rcn_seq_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(string name, rcn_pkg::rcn_data_t got, rcn_pkg::rcn_data_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_ops();
        int          fd;
        int          kind;
        string       line;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ed;
        logic [3:0]  m;
        logic        e;
        fd = $fopen("tb/rcn_ring_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file tb/rcn_ring_testdata.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h %h %h", kind, a, m, wd, ed, e) == 6) begin
                op_kind.push_back(kind);
                op_addr.push_back(a);
                op_mask.push_back(m);
                op_wdata.push_back(wd);
                op_exp.push_back(ed);
                op_err.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // advances one clock and counts a credit pulse seen in the cycle before the edge
    task automatic next_cycle();
        @(posedge clk);
        req_valid <= 1'b0;
        if (req_credit === 1'b1)
            credits++;
        if (credits > ring_cfg_pkg::REQ_CREDITS) begin
            $display("at %0t ns the DUT returned more credits than the source spent", $time);
            abort_run();
        end
    endtask

    task automatic issue(int idx);
        while (credits == 0)
            next_cycle();
        credits--;
        req_valid <= 1'b1;
        req_wr    <= (op_kind[idx] == 1);
        req_addr  <= op_addr[idx];
        req_mask  <= op_mask[idx];
        req_data  <= op_wdata[idx];
        exp_seq_q.push_back(next_seq);
        exp_data_q.push_back(op_exp[idx]);
        exp_err_q.push_back(op_err[idx]);
        next_seq = next_seq + 1'b1; // wraps modulo 16 like the master's tag
    endtask

    task automatic drain();
        while (exp_data_q.size() != 0)
            next_cycle();
    endtask

    always @(posedge clk) begin
        if (rsp_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                $display("response at %0t ns with no request outstanding", $time);
                abort_run();
            end
            check_seq("rsp_seq", rsp_seq, exp_seq_q.pop_front());
            check_data("rsp_data", rsp_data, exp_data_q.pop_front());
            check_err("rsp_err", rsp_err, exp_err_q.pop_front());
        end
    end

    // budget per operation covers the ring, the largest gap and a full queue ahead of it
    initial begin
        wait (n_ops > 0);
        repeat (n_ops * (RING_LAT + MAX_GAP + ring_cfg_pkg::REQ_CREDITS) + 50) @(posedge clk);
        $display("timeout at %0t ns, %0d responses still missing", $time, exp_data_q.size());
        abort_run();
    end

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_mask  = '0;
        req_data  = '0;
        credits   = ring_cfg_pkg::REQ_CREDITS;
        next_seq  = '0;
        void'($urandom(32'h7a57));
        load_ops();
        if (op_kind.size() == 0) begin
            $display("the test data file holds no operations");
            abort_run();
        end
        n_ops = op_kind.size();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        check_err("req_credit", req_credit, 1'b0);
        check_err("rsp_valid", rsp_valid, 1'b0);
        check_reg("test_progress", test_progress, '0);
        check_reg("test_fail", test_fail, '0);
        check_reg("test_pass", test_pass, '0);
        for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == 2) begin
                drain();
                case (op_addr[i][3:2])
                    2'd0:    check_reg("test_progress", test_progress, op_exp[i]);
                    2'd1:    check_reg("test_fail", test_fail, op_exp[i]);
                    default: check_reg("test_pass", test_pass, op_exp[i]);
                endcase
            end else begin
                gap = ($urandom % 3 == 0) ? 1 + $urandom % MAX_GAP : 0; // mostly back to back
                repeat (gap) next_cycle();
                next_cycle();
                issue(i);
            end
        end
        drain();
        if (credits != ring_cfg_pkg::REQ_CREDITS) begin
            $display("source holds %0d credits after the last response instead of %0d",
                     credits, ring_cfg_pkg::REQ_CREDITS);
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* rcn_ring.f */
rtl/rcn_pkg.sv
rtl/ring_cfg_pkg.sv
rtl/rcn_if.sv
rtl/rcn_master.sv
rtl/rcn_testregs.sv
rtl/rcn_ram.sv
rtl/rcn_delay.sv
rtl/rcn_ring_top.sv
tb/rcn_ring_tb.sv

/* Makefile */
TOP = rcn_ring_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

obj_dir/V$(TOP): rcn_ring.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f rcn_ring.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f rcn_ring.f

clean:
	rm -rf obj_dir sim.log

/* tb/rcn_ring_testdata.txt */
// kind addr mask wdata exp_data exp_err, all hex
// kind 0 read, 1 write, 2 compare the test register output at addr once the ring is empty
1 00000010 f deadbeef deadbeef 0
0 00000010 0 00000000 deadbeef 0
1 00000010 3 12345678 dead5678 0
0 00000010 0 00000000 dead5678 0
1 fffffff0 f 11223344 11223344 0
1 fffffff0 4 aabbccdd 11bb3344 0
0 fffffff0 0 00000000 11bb3344 0
2 fffffff0 0 00000000 11bb3344 0
1 fffffff4 1 000000a5 000000a5 0
1 fffffff8 c 5a5a0000 5a5a0000 0
2 fffffff4 0 00000000 000000a5 0
2 fffffff8 0 00000000 5a5a0000 0
0 00000400 0 00000000 00000000 1
1 80000000 f 01020304 00000000 1
0 fffffffc 0 00000000 00000000 1
1 00000020 f 11110020 11110020 0
1 00000024 f 22220024 22220024 0
1 00000028 f 33330028 33330028 0
1 0000002c f 4444002c 4444002c 0
0 00000020 0 00000000 11110020 0
0 00000024 0 00000000 22220024 0
0 00000028 0 00000000 33330028 0
0 0000002c 0 00000000 4444002c 0
